// File: source/pcs_lane_pkg.sv
// PCS block layout with the sync header in the low bits; simplified marker format
package pcs_lane_pkg;

        // one PCS block is a 2-bit sync header plus 64 payload bits
        localparam int NB_BLOCK = 66;
        localparam int NB_SYNC  = 2;
        localparam int NB_BYTE  = 8;

        // sync header of a control block
        localparam logic [NB_SYNC-1:0] SYNC_CTRL = 2'b10;

        // payload byte 0 of an alignment marker
        localparam logic [NB_BYTE-1:0] AM_CODE = 8'h4b;

        // marker payload layout, counted from bit 0 of the block:
        //   [1:0]   sync header
        //   [9:2]   marker code
        //   [17:10] logical lane number
        //   [25:18] bitwise complement of the lane number
        localparam int AM_CODE_LSB   = NB_SYNC;
        localparam int AM_ID_LSB     = NB_SYNC + NB_BYTE;
        localparam int AM_ID_INV_LSB = NB_SYNC + (2 * NB_BYTE);

        // mapping walk state
        //   MAP_IDLE   waiting for every lane to lock
        //   MAP_WALK   one physical lane per valid cycle
        //   MAP_DONE   built selector in use
        //   MAP_ERROR  duplicate or out-of-range id seen, identity kept
        typedef enum logic [1:0]
        {
                MAP_IDLE  = 2'd0,
                MAP_WALK  = 2'd1,
                MAP_DONE  = 2'd2,
                MAP_ERROR = 2'd3
        } map_state_t;

endpackage

// File: source/lane_id_detector.sv
// lock needs two equal markers in a row; ids of N_LANES or more never lock (N_LANES <= 32)
`timescale 1ns/1ps

module lane_id_detector
#(
        parameter int N_LANES = 20,
        parameter int NB_ID   = $clog2(N_LANES)
)
(
        input  logic                                    i_clock,
        input  logic                                    i_reset,
        input  logic                                    i_valid,
        input  logic [pcs_lane_pkg::NB_BLOCK-1:0]       i_block,
        output logic [NB_ID-1:0]                        o_logical_id,
        output logic                                    o_id_locked
);

        localparam logic [pcs_lane_pkg::NB_BYTE-1:0] ID_LIMIT = pcs_lane_pkg::NB_BYTE'(N_LANES);

        logic [pcs_lane_pkg::NB_SYNC-1:0]       w_sync;
        logic [pcs_lane_pkg::NB_BYTE-1:0]       w_code;
        logic [pcs_lane_pkg::NB_BYTE-1:0]       w_id_byte;
        logic [pcs_lane_pkg::NB_BYTE-1:0]       w_id_inv;
        logic                                   w_is_marker;
        logic                                   w_id_in_range;
        logic [NB_ID-1:0]                       w_rx_id;
        logic [NB_ID-1:0]                       r_id;
        logic                                   r_seen;
        logic                                   r_locked;

        // field split of the incoming block
        assign w_sync    = i_block[pcs_lane_pkg::NB_SYNC-1:0];
        assign w_code    = i_block[pcs_lane_pkg::AM_CODE_LSB +: pcs_lane_pkg::NB_BYTE];
        assign w_id_byte = i_block[pcs_lane_pkg::AM_ID_LSB +: pcs_lane_pkg::NB_BYTE];
        assign w_id_inv  = i_block[pcs_lane_pkg::AM_ID_INV_LSB +: pcs_lane_pkg::NB_BYTE];

        // a bad complement byte means this is not a marker at all
        assign w_is_marker = i_valid
                             && (w_sync == pcs_lane_pkg::SYNC_CTRL)
                             && (w_code == pcs_lane_pkg::AM_CODE)
                             && (w_id_inv == ~w_id_byte);

        assign w_id_in_range = (w_id_byte < ID_LIMIT);
        assign w_rx_id       = w_id_byte[NB_ID-1:0];

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        r_id     <= '0;
                        r_seen   <= 1'b0;
                        r_locked <= 1'b0;
                end
                else if (w_is_marker)
                begin
                        if (!w_id_in_range)
                        begin
                                // out-of-range id, forget whatever was stored
                                r_seen   <= 1'b0;
                                r_locked <= 1'b0;
                        end
                        else if (r_seen && (w_rx_id == r_id))
                        begin
                                // second marker agrees
                                r_locked <= 1'b1;
                        end
                        else
                        begin
                                // first marker or a changed id
                                r_id     <= w_rx_id;
                                r_seen   <= 1'b1;
                                r_locked <= 1'b0;
                        end
                end
        end

        assign o_logical_id = r_id;
        assign o_id_locked  = r_locked;

endmodule

// File: source/lane_reorder_map.sv
// selector slot k names the physical lane feeding logical lane k; identity outside MAP_DONE
`timescale 1ns/1ps

module lane_reorder_map
#(
        parameter int N_LANES = 20,
        parameter int NB_ID   = $clog2(N_LANES)
)
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        input  logic                            i_reset_order,
        input  logic                            i_enable,
        input  logic                            i_valid,
        input  logic                            i_deskew_done,
        input  logic [N_LANES-1:0]              i_id_locked,
        input  logic [N_LANES*NB_ID-1:0]        i_logical_id,
        output logic [N_LANES*NB_ID-1:0]        o_mux_selector,
        output logic                            o_reorder_done,
        output logic                            o_map_error
);

        // one extra bit so that N_LANES = 32 still compares correctly
        localparam logic [NB_ID:0]   ID_LIMIT  = (NB_ID+1)'(N_LANES);
        localparam logic [NB_ID-1:0] LAST_LANE = NB_ID'(N_LANES - 1);

        pcs_lane_pkg::map_state_t       r_state;
        logic [NB_ID-1:0]               r_lane;
        logic [N_LANES-1:0]             r_present;
        logic                           r_bad;
        logic [NB_ID-1:0]               r_map [N_LANES];
        logic [NB_ID-1:0]               w_cur_id;
        logic                           w_in_range;
        logic                           w_dup;
        logic                           w_step_bad;
        logic                           w_all_locked;
        logic                           w_start;
        logic                           w_step;

        assign w_all_locked = &i_id_locked;

        assign w_start = (r_state == pcs_lane_pkg::MAP_IDLE)
                         && w_all_locked && i_enable && i_deskew_done;

        // one physical lane per enabled valid cycle
        assign w_step = (r_state == pcs_lane_pkg::MAP_WALK)
                        && w_all_locked && i_valid && i_enable;

        assign w_cur_id   = i_logical_id[r_lane*NB_ID +: NB_ID];
        assign w_in_range = ({1'b0, w_cur_id} < ID_LIMIT);
        assign w_dup      = w_in_range && r_present[w_cur_id];
        assign w_step_bad = !w_in_range || w_dup;

        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_reset_order)
                begin
                        r_state   <= pcs_lane_pkg::MAP_IDLE;
                        r_lane    <= '0;
                        r_present <= '0;
                        r_bad     <= 1'b0;
                end
                else
                begin
                        case (r_state)
                        pcs_lane_pkg::MAP_IDLE:
                        begin
                                if (w_start)
                                begin
                                        r_state   <= pcs_lane_pkg::MAP_WALK;
                                        r_lane    <= '0;
                                        r_present <= '0;
                                        r_bad     <= 1'b0;
                                end
                        end
                        pcs_lane_pkg::MAP_WALK:
                        begin
                                if (!w_all_locked)
                                begin
                                        // a lane lost its marker lock, start over
                                        r_state <= pcs_lane_pkg::MAP_IDLE;
                                end
                                else if (w_step)
                                begin
                                        if (w_in_range)
                                                r_present[w_cur_id] <= 1'b1;
                                        r_bad <= r_bad || w_step_bad;
                                        if (r_lane == LAST_LANE)
                                        begin
                                                if (r_bad || w_step_bad)
                                                        r_state <= pcs_lane_pkg::MAP_ERROR;
                                                else
                                                        r_state <= pcs_lane_pkg::MAP_DONE;
                                        end
                                        else
                                        begin
                                                r_lane <= r_lane + 1'b1;
                                        end
                                end
                        end
                        // done and error hold until a reset or a reorder restart
                        default:
                        begin
                                r_state <= r_state;
                        end
                        endcase
                end
        end

        // built map, every slot is written once on a clean walk
        always_ff @(posedge i_clock)
        begin
                if (w_step && !w_step_bad)
                        r_map[w_cur_id] <= r_lane;
        end

        for (genvar k = 0; k < N_LANES; k++)
        begin : g_selector
                assign o_mux_selector[k*NB_ID +: NB_ID] =
                        (r_state == pcs_lane_pkg::MAP_DONE) ? r_map[k] : NB_ID'(k);
        end

        assign o_reorder_done = (r_state == pcs_lane_pkg::MAP_DONE);
        assign o_map_error    = (r_state == pcs_lane_pkg::MAP_ERROR);

endmodule

// File: source/lane_reorder_mux.sv
// one-cycle registered crossbar; a selector slot of N_LANES or more gives an all-zero block
`timescale 1ns/1ps

module lane_reorder_mux
#(
        parameter int N_LANES = 20,
        parameter int NB_ID   = $clog2(N_LANES)
)
(
        input  logic                                            i_clock,
        input  logic                                            i_reset,
        input  logic                                            i_valid,
        input  logic [N_LANES*pcs_lane_pkg::NB_BLOCK-1:0]       i_blocks,
        input  logic [N_LANES*NB_ID-1:0]                        i_selector,
        output logic [N_LANES*pcs_lane_pkg::NB_BLOCK-1:0]       o_blocks,
        output logic                                            o_valid
);

        localparam int               NB_BLOCK = pcs_lane_pkg::NB_BLOCK;
        localparam logic [NB_ID:0]   SEL_LIMIT = (NB_ID+1)'(N_LANES);

        logic [NB_BLOCK-1:0]            w_lane_in [N_LANES];
        logic [N_LANES*NB_BLOCK-1:0]    w_routed;
        logic [N_LANES*NB_BLOCK-1:0]    r_blocks;
        logic                           r_valid;

        for (genvar k = 0; k < N_LANES; k++)
        begin : g_route
                logic [NB_ID-1:0] w_sel;

                assign w_lane_in[k] = i_blocks[k*NB_BLOCK +: NB_BLOCK];
                assign w_sel        = i_selector[k*NB_ID +: NB_ID];

                // logical lane k takes the physical lane named in slot k
                assign w_routed[k*NB_BLOCK +: NB_BLOCK] =
                        ({1'b0, w_sel} < SEL_LIMIT) ? w_lane_in[w_sel] : '0;
        end

        // data only moves on a valid cycle
        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        r_blocks <= w_routed;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        r_valid <= 1'b0;
                else
                        r_valid <= i_valid;
        end

        assign o_blocks = r_blocks;
        assign o_valid  = r_valid;

endmodule

// File: source/pcs_rx_lane_reorder_top.sv
// rx lane reorder without block lock, deskew or marker removal; one cycle data latency
`timescale 1ns/1ps

module pcs_rx_lane_reorder_top
#(
        parameter int N_LANES = 20,
        parameter int NB_ID   = $clog2(N_LANES)
)
(
        input  logic                                            i_clock,
        input  logic                                            i_reset,
        input  logic                                            i_reset_order,
        input  logic                                            i_enable,
        input  logic                                            i_deskew_done,
        input  logic                                            i_valid,
        input  logic [N_LANES*pcs_lane_pkg::NB_BLOCK-1:0]       i_rx_blocks,
        output logic [N_LANES*pcs_lane_pkg::NB_BLOCK-1:0]       o_tx_blocks,
        output logic                                            o_valid,
        output logic                                            o_reorder_done,
        output logic                                            o_map_error
);

        logic [N_LANES*NB_ID-1:0]       w_logical_id;
        logic [N_LANES-1:0]             w_id_locked;
        logic [N_LANES*NB_ID-1:0]       w_mux_selector;

        // one marker detector per physical lane, lane 0 in the lowest slice
        for (genvar g = 0; g < N_LANES; g++)
        begin : g_detector
                lane_id_detector
                #(
                        .N_LANES        (N_LANES),
                        .NB_ID          (NB_ID)
                )
                lane_id_detector_i
                (
                        .i_clock        (i_clock),
                        .i_reset        (i_reset),
                        .i_valid        (i_valid),
                        .i_block        (i_rx_blocks[g*pcs_lane_pkg::NB_BLOCK +:
                                                     pcs_lane_pkg::NB_BLOCK]),
                        .o_logical_id   (w_logical_id[g*NB_ID +: NB_ID]),
                        .o_id_locked    (w_id_locked[g])
                );
        end

        lane_reorder_map
        #(
                .N_LANES        (N_LANES),
                .NB_ID          (NB_ID)
        )
        lane_reorder_map_i
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_reset_order  (i_reset_order),
                .i_enable       (i_enable),
                .i_valid        (i_valid),
                .i_deskew_done  (i_deskew_done),
                .i_id_locked    (w_id_locked),
                .i_logical_id   (w_logical_id),
                .o_mux_selector (w_mux_selector),
                .o_reorder_done (o_reorder_done),
                .o_map_error    (o_map_error)
        );

        // identity until the map reports done
        lane_reorder_mux
        #(
                .N_LANES        (N_LANES),
                .NB_ID          (NB_ID)
        )
        lane_reorder_mux_i
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_valid        (i_valid),
                .i_blocks       (i_rx_blocks),
                .i_selector     (w_mux_selector),
                .o_blocks       (o_tx_blocks),
                .o_valid        (o_valid)
        );

endmodule

// File: verif/pcs_rx_lane_reorder_properties.sv
// bound to pcs_rx_lane_reorder_top; valid and flag checks pause while i_reset is high
`timescale 1ns/1ps

module pcs_rx_lane_reorder_properties
(
        input  logic    i_clock,
        input  logic    i_reset,
        input  logic    i_valid,
        input  logic    i_out_valid,
        input  logic    i_reorder_done,
        input  logic    i_map_error
);

        // done and error are two states of one FSM
        a_flags_exclusive: assert property (
                @(posedge i_clock) disable iff (i_reset)
                !(i_reorder_done && i_map_error))
                else $error("o_reorder_done and o_map_error are high together");

        // one cycle from i_valid to o_valid, both ways
        a_valid_delay: assert property (
                @(posedge i_clock) disable iff (i_reset)
                i_valid |=> i_out_valid)
                else $error("o_valid missing one cycle after i_valid");

        a_no_extra_valid: assert property (
                @(posedge i_clock) disable iff (i_reset)
                !i_valid |=> !i_out_valid)
                else $error("o_valid high without i_valid one cycle before");

        a_reset_outputs: assert property (
                @(posedge i_clock)
                i_reset |=> (!i_out_valid && !i_reorder_done && !i_map_error))
                else $error("outputs not low during reset");

endmodule

bind pcs_rx_lane_reorder_top pcs_rx_lane_reorder_properties pcs_rx_lane_reorder_properties_i
(
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_out_valid    (o_valid),
        .i_reorder_done (o_reorder_done),
        .i_map_error    (o_map_error)
);

// File: verif/tb_pcs_rx_lane_reorder.sv
// reads verif/lane_reorder_patterns.txt relative to the project root; written for N_LANES = 20
`timescale 1ns/1ps

module tb_pcs_rx_lane_reorder;

        localparam int N_LANES     = 20;
        localparam int NB_ID       = $clog2(N_LANES);
        localparam int NB_BLOCK    = pcs_lane_pkg::NB_BLOCK;
        localparam int N_CASES     = 7;
        localparam int CASE_WORDS  = N_LANES + 3;
        localparam int WAIT_LIMIT  = 80;
        localparam int DATA_CYCLES = 12;

        logic                           i_clock;
        logic                           i_reset;
        logic                           i_reset_order;
        logic                           i_enable;
        logic                           i_deskew_done;
        logic                           i_valid;
        logic [N_LANES*NB_BLOCK-1:0]    i_rx_blocks;
        logic [N_LANES*NB_BLOCK-1:0]    o_tx_blocks;
        logic                           o_valid;
        logic                           o_reorder_done;
        logic                           o_map_error;

        logic [7:0]                     patterns [0:N_CASES*CASE_WORDS-1];
        logic [7:0]                     case_ids [N_LANES];
        int                             exp_src [N_LANES];
        logic                           sent_valid;
        logic [N_LANES*NB_BLOCK-1:0]    sent_blocks;
        integer                         seed;
        int                             checks;
        int                             data_errors;
        int                             flag_errors;
        int                             other_errors;
        int                             timeouts;

        pcs_rx_lane_reorder_top
        #(
                .N_LANES        (N_LANES),
                .NB_ID          (NB_ID)
        )
        pcs_rx_lane_reorder_top_i
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_reset_order  (i_reset_order),
                .i_enable       (i_enable),
                .i_deskew_done  (i_deskew_done),
                .i_valid        (i_valid),
                .i_rx_blocks    (i_rx_blocks),
                .o_tx_blocks    (o_tx_blocks),
                .o_valid        (o_valid),
                .o_reorder_done (o_reorder_done),
                .o_map_error    (o_map_error)
        );

        always #20 i_clock = ~i_clock;

        // outputs are stable here, inputs change here
        task automatic clock_step;
                @(posedge i_clock);
                #2;
        endtask

        task automatic drive_cycle(input logic valid, input logic [N_LANES*NB_BLOCK-1:0] blocks);
                i_valid     = valid;
                i_rx_blocks = blocks;
                sent_valid  = valid;
                sent_blocks = blocks;
                clock_step();
        endtask

        task automatic apply_reset;
                i_reset    = 1'b1;
                i_valid    = 1'b0;
                sent_valid = 1'b0;
                repeat (8) clock_step();
                i_reset = 1'b0;
        endtask

        // data blocks carry the data sync header, so no lane sees a marker
        task automatic random_blocks(output logic [N_LANES*NB_BLOCK-1:0] blocks);
                for (int p = 0; p < N_LANES; p++)
                        blocks[p*NB_BLOCK +: NB_BLOCK] = {$random(seed), $random(seed), 2'b01};
        endtask

        task automatic marker_blocks(input logic corrupt,
                                     output logic [N_LANES*NB_BLOCK-1:0] blocks);
                logic [7:0] inv;
                for (int p = 0; p < N_LANES; p++)
                begin
                        inv = ~case_ids[p];
                        if (corrupt && (p == 0))
                                inv = inv ^ 8'h01;
                        blocks[p*NB_BLOCK +: NB_BLOCK] = {40'h0, inv, case_ids[p],
                                pcs_lane_pkg::AM_CODE, pcs_lane_pkg::SYNC_CTRL};
                end
        endtask

        task automatic check_blocks(input logic [NB_BLOCK-1:0] actual,
                                    input logic [NB_BLOCK-1:0] expected, input int lane);
                checks++;
                if (actual !== expected)
                begin
                        data_errors++;
                        $display("error: o_tx_blocks lane %0d = %h, expected %h",
                                 lane, actual, expected);
                end
        endtask

        task automatic check_flag(input string name, input logic actual, input logic expected);
                checks++;
                if (actual !== expected)
                begin
                        flag_errors++;
                        $display("error: %s = %h, expected %h", name, actual, expected);
                end
        endtask

        task automatic check_state_flags(input logic done, input logic err,
                                         input logic exp_done, input logic exp_err,
                                         input int case_idx);
                checks++;
                if ({done, err} !== {exp_done, exp_err})
                begin
                        flag_errors++;
                        $display("error: o_reorder_done,o_map_error = %h, expected %h, case %0d",
                                 {done, err}, {exp_done, exp_err}, case_idx);
                end
        endtask

        // output lane k against the block sent on its source lane
        task automatic check_outputs(input logic use_map);
                int src;
                check_flag("o_valid", o_valid, sent_valid);
                if (sent_valid)
                begin
                        for (int k = 0; k < N_LANES; k++)
                        begin
                                src = use_map ? exp_src[k] : k;
                                check_blocks(o_tx_blocks[k*NB_BLOCK +: NB_BLOCK],
                                             sent_blocks[src*NB_BLOCK +: NB_BLOCK], k);
                        end
                end
        endtask

        task automatic run_case(input int c);
                int                             base;
                int                             id;
                int                             waited;
                int                             sent;
                int                             seen;
                logic [7:0]                     mode;
                logic                           exp_done;
                logic                           exp_err;
                logic                           v;
                logic [N_LANES*NB_BLOCK-1:0]    blocks;
                base     = c * CASE_WORDS;
                mode     = patterns[base];
                exp_done = patterns[base + N_LANES + 1][0];
                exp_err  = patterns[base + N_LANES + 2][0];
                for (int k = 0; k < N_LANES; k++)
                        exp_src[k] = k;
                for (int p = 0; p < N_LANES; p++)
                begin
                        case_ids[p] = patterns[base + 1 + p];
                        id = case_ids[p];
                        if (id < N_LANES)
                                exp_src[id] = p;
                end

                // deskew held low so a restart does not walk stale ids
                i_deskew_done = 1'b0;
                if (mode[0])
                begin
                        i_reset_order = 1'b1;
                        drive_cycle(1'b0, sent_blocks);
                        i_reset_order = 1'b0;
                end
                else
                begin
                        apply_reset();
                end

                // identity order before any markers
                random_blocks(blocks);
                drive_cycle(1'b1, blocks);
                check_outputs(1'b0);
                check_state_flags(o_reorder_done, o_map_error, 1'b0, 1'b0, c);

                marker_blocks(mode[1], blocks);
                drive_cycle(1'b1, blocks);
                drive_cycle(1'b1, blocks);
                i_deskew_done = 1'b1;

                waited = 0;
                while (!(o_reorder_done || o_map_error) && (waited < WAIT_LIMIT))
                begin
                        random_blocks(blocks);
                        drive_cycle(1'b1, blocks);
                        waited++;
                end
                if (!(o_reorder_done || o_map_error) && (exp_done || exp_err))
                begin
                        timeouts++;
                        $display("timeout: no done or error flag after %0d cycles in case %0d",
                                 WAIT_LIMIT, c);
                end
                check_state_flags(o_reorder_done, o_map_error, exp_done, exp_err, c);

                // valid pairs with a gap between them
                sent = 0;
                seen = 0;
                for (int n = 0; n < DATA_CYCLES; n++)
                begin
                        v = ((n % 3) != 2);
                        random_blocks(blocks);
                        drive_cycle(v, blocks);
                        check_outputs(exp_done);
                        if (v)
                                sent++;
                        if (o_valid)
                                seen++;
                end
                if (seen != sent)
                begin
                        other_errors++;
                        $display("case %0d lost valid blocks: %0d sent, %0d forwarded",
                                 c, sent, seen);
                end
        endtask

        initial
        begin
                #200000;
                $display("timeout: simulation did not reach its end");
                $display("SIMULATION FAILED");
                $finish;
        end

        initial
        begin
                i_clock       = 1'b0;
                i_reset       = 1'b1;
                i_reset_order = 1'b0;
                i_enable      = 1'b1;
                i_deskew_done = 1'b0;
                i_valid       = 1'b0;
                i_rx_blocks   = '0;
                sent_valid    = 1'b0;
                sent_blocks   = '0;
                seed          = 32'h61b;
                checks        = 0;
                data_errors   = 0;
                flag_errors   = 0;
                other_errors  = 0;
                timeouts      = 0;

                $readmemh("verif/lane_reorder_patterns.txt", patterns);
                if ($isunknown(patterns[0]) || $isunknown(patterns[N_CASES*CASE_WORDS-1]))
                begin
                        other_errors++;
                        $display("pattern file could not be read completely");
                end
                else
                begin
                        for (int c = 0; c < N_CASES; c++)
                                run_case(c);
                end

                $display("checks %0d, errors: data %0d flag %0d other %0d timeout %0d",
                         checks, data_errors, flag_errors, other_errors, timeouts);
                if ((data_errors + flag_errors + other_errors + timeouts) == 0)
                        $display("SIMULATION PASSED");
                else
                        $display("SIMULATION FAILED");
                $finish;
        end

endmodule

// File: project.f
source/pcs_lane_pkg.sv
source/lane_id_detector.sv
source/lane_reorder_map.sv
source/lane_reorder_mux.sv
source/pcs_rx_lane_reorder_top.sv
verif/pcs_rx_lane_reorder_properties.sv
verif/tb_pcs_rx_lane_reorder.sv

// File: Makefile
TOOL      = verilator
TOP       = tb_pcs_rx_lane_reorder
FILELIST  = project.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -j 0
LOG       = sim.log
FAIL_MSG  = SIMULATION FAILED
PASS_MSG  = SIMULATION PASSED
BIN       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator runs from the project root so the pattern file is found
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a verdict"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/lane_reorder_patterns.txt
// columns: mode, logical id sent on physical lanes 0 to 19, expected done, expected error
// mode bit 0 restarts with i_reset_order instead of i_reset, bit 1 corrupts lane 0 complement byte
// reversed order after reset
00 13 12 11 10 0f 0e 0d 0c 0b 0a 09 08 07 06 05 04 03 02 01 00 01 00
// rotation by five after a reorder restart
01 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 00 01 02 03 04 01 00
// lane 7 repeats id 3
01 00 01 02 03 04 05 06 03 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 00 01
// lane 4 carries id 24, out of range
01 00 01 02 03 18 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 00 00
// bad complement byte on lane 0 after reset
02 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 00 00
// stride of three after reset
00 00 03 06 09 0c 0f 12 01 04 07 0a 0d 10 13 02 05 08 0b 0e 11 01 00
// pairwise swap after a reorder restart that follows a done mapping
01 01 00 03 02 05 04 07 06 09 08 0b 0a 0d 0c 0f 0e 11 10 13 12 01 00
